// ==== sources.f ====
logic/wsn_pkg.sv
logic/node_memory.sv
logic/hop_selector.sv
logic/feedback_builder.sv
logic/cluster_node.sv
testbench/cluster_node_checker.sv
testbench/cluster_node_tb.sv

// ==== testbench/cluster_node_tb.sv ====
`timescale 1ns/100ps

module cluster_node_tb;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM = 12;
    // longest scan, hand-off, build and some polling slack
    localparam int RUN_CYCLES = int'(wsn_pkg::MAX_NEIGHBORS) + 2 + wsn_pkg::BUILD_CYCLES + 20;
    // memory writes that may come ahead of one window
    localparam int LOAD_CYCLES = 256;
    // random runs plus the directed windows
    localparam int NUM_SLOTS = NUM_RANDOM + 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_SLOTS * (RUN_CYCLES + LOAD_CYCLES);

    logic               done_prev;
    logic               rst_n;
    wsn_pkg::word_t     node_id;
    wsn_pkg::word_t     cluster_id;
    logic               start;
    wsn_pkg::nbr_idx_t  action;
    wsn_pkg::nbr_cnt_t  neighbor_count;
    logic               wr_en;
    wsn_pkg::addr_t     wr_addr;
    wsn_pkg::word_t     wr_data;
    wsn_pkg::feedback_t feedback;
    logic               done;
    wsn_pkg::nbr_idx_t  best_hop;
    logic               hop_valid;
    logic               busy;

    // tb copy of every word written into the node memory
    wsn_pkg::word_t mirror [wsn_pkg::MEM_DEPTH];

    // expected results with one entry per accepted start
    wsn_pkg::nbr_idx_t  exp_hop_q [$];
    wsn_pkg::feedback_t exp_fb_q [$];

    int accepted_cnt = 0;
    int hop_cnt = 0;
    int done_cnt = 0;
    int cycle_cnt = 0;
    int err_hop = 0;
    int err_fb = 0;
    int err_flag = 0;
    int err_seq = 0;

    logic [31:0] lfsr_state = 32'd78742;

    wsn_pkg::nbr_cnt_t n;
    wsn_pkg::nbr_idx_t act;
    int hop_mark;
    int done_mark;

    cluster_node dut_i (
        .done_prev      (done_prev),
        .rst_n          (rst_n),
        .node_id        (node_id),
        .cluster_id     (cluster_id),
        .start          (start),
        .action         (action),
        .neighbor_count (neighbor_count),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .feedback       (feedback),
        .done           (done),
        .best_hop       (best_hop),
        .hop_valid      (hop_valid),
        .busy           (busy)
    );

    initial begin
        done_prev = 1'b0;
        forever #5 done_prev = ~done_prev;
    end

    // galois form shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hD000_0001;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // first index of the largest q-value, then the packet fields from the mirror
    function automatic wsn_pkg::feedback_t ref_packet(input wsn_pkg::nbr_cnt_t cnt,
                                                      input wsn_pkg::nbr_idx_t act_in,
                                                      output wsn_pkg::nbr_idx_t hop);
        wsn_pkg::word_t best;
        wsn_pkg::word_t batt;
        wsn_pkg::word_t dest;
        best = mirror[wsn_pkg::QVALUE_BASE];
        hop = '0;
        for (int i = 1; i < int'(cnt); i++) begin
            if (mirror[wsn_pkg::QVALUE_BASE + wsn_pkg::addr_t'(i)] > best) begin
                best = mirror[wsn_pkg::QVALUE_BASE + wsn_pkg::addr_t'(i)];
                hop = wsn_pkg::nbr_idx_t'(i);
            end
        end
        batt = mirror[wsn_pkg::BATTERY_BASE + wsn_pkg::addr_t'(node_id)];
        dest = mirror[wsn_pkg::DEST_BASE + wsn_pkg::addr_t'(act_in)];
        return {node_id, batt, best, cluster_id, dest};
    endfunction

    task automatic check_hop(input wsn_pkg::nbr_idx_t got, input wsn_pkg::nbr_idx_t exp);
        if (got !== exp) begin
            $display("FAILED best_hop: got 0x%02h expected 0x%02h", got, exp);
            err_hop++;
        end
    endtask

    task automatic check_feedback(input wsn_pkg::feedback_t got, input wsn_pkg::feedback_t exp);
        if (got !== exp) begin
            $display("FAILED feedback: got 0x%020h expected 0x%020h", got, exp);
            err_fb++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%01h expected 0x%01h", name, got, exp);
            err_flag++;
        end
    endtask

    function automatic int total_errors();
        return err_hop + err_fb + err_flag + err_seq + dut_i.chk_i.fail_cnt;
    endfunction

    task automatic print_summary();
        $display("error counts: best_hop %0d, feedback %0d, flags %0d, seq %0d, assert %0d",
                 err_hop, err_fb, err_flag, err_seq, dut_i.chk_i.fail_cnt);
    endtask

    // all tasks below start and end 1 ns after a rising edge
    task automatic write_word(input wsn_pkg::addr_t addr, input wsn_pkg::word_t data);
        wr_en = 1'b1;
        wr_addr = addr;
        wr_data = data;
        mirror[addr] = data;
        @(posedge done_prev);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic load_qvalues(input int bits);
        for (int i = 0; i < int'(wsn_pkg::MAX_NEIGHBORS); i++) begin
            write_word(wsn_pkg::QVALUE_BASE + wsn_pkg::addr_t'(i),
                       wsn_pkg::word_t'(rand_bits(bits)));
        end
    endtask

    task automatic pulse_start(input wsn_pkg::nbr_cnt_t cnt, input wsn_pkg::nbr_idx_t act_in);
        start = 1'b1;
        neighbor_count = cnt;
        action = act_in;
        @(posedge done_prev);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge done_prev);
            #1;
        end while (busy || (done_cnt != accepted_cnt));
    endtask

    // only called with busy low, so the start is taken
    task automatic issue_scan(input wsn_pkg::nbr_cnt_t cnt, input wsn_pkg::nbr_idx_t act_in);
        wsn_pkg::nbr_idx_t hop;
        wsn_pkg::feedback_t pkt;
        pkt = ref_packet(cnt, act_in, hop);
        exp_hop_q.push_back(hop);
        exp_fb_q.push_back(pkt);
        accepted_cnt++;
        pulse_start(cnt, act_in);
    endtask

    task automatic run_scan(input wsn_pkg::nbr_cnt_t cnt, input wsn_pkg::nbr_idx_t act_in);
        issue_scan(cnt, act_in);
        wait_idle();
    endtask

    // compare process samples registered outputs mid-cycle
    always @(negedge done_prev) begin
        if (rst_n) begin
            if (hop_valid) begin
                hop_cnt++;
                if (exp_hop_q.size() == 0) begin
                    $display("hop_valid pulse arrived with no scan pending");
                    err_seq++;
                end else begin
                    check_hop(best_hop, exp_hop_q.pop_front());
                end
            end
            if (done) begin
                done_cnt++;
                if (exp_fb_q.size() == 0) begin
                    $display("done pulse arrived with no packet pending");
                    err_seq++;
                end else begin
                    check_feedback(feedback, exp_fb_q.pop_front());
                end
            end
        end
    end

    always @(posedge done_prev) begin
        cycle_cnt++;
    end

    initial begin
        wait (cycle_cnt == TIMEOUT_CYCLES);
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_summary();
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        action = '0;
        neighbor_count = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        // node ids stay below 128
        node_id = wsn_pkg::word_t'(rand_bits(7));
        cluster_id = wsn_pkg::word_t'(rand_bits(16));
        repeat (RESET_CYCLES) @(posedge done_prev);
        #1;
        rst_n = 1'b1;

        // quiet outputs before any start
        repeat (4) begin
            @(posedge done_prev);
            #1;
            check_flag("done", done, 1'b0);
            check_flag("hop_valid", hop_valid, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_feedback(feedback, '0);
            check_hop(best_hop, '0);
        end

        // neighbor ids and the whole battery region
        for (int i = 0; i < int'(wsn_pkg::MAX_NEIGHBORS); i++) begin
            write_word(wsn_pkg::DEST_BASE + wsn_pkg::addr_t'(i),
                       wsn_pkg::word_t'(rand_bits(7)));
        end
        for (int i = 0; i < 128; i++) begin
            write_word(wsn_pkg::BATTERY_BASE + wsn_pkg::addr_t'(i),
                       wsn_pkg::word_t'(rand_bits(16)));
        end

        // random tables and counts 1..64 with the first two runs at the limits
        for (int r = 0; r < NUM_RANDOM; r++) begin
            load_qvalues(16);
            n = wsn_pkg::nbr_cnt_t'(rand_bits(6)) + 7'd1;
            if (r == 0) begin
                n = wsn_pkg::MAX_NEIGHBORS;
            end else if (r == 1) begin
                n = 7'd1;
            end
            act = wsn_pkg::nbr_idx_t'(rand_bits(6));
            run_scan(n, act);
        end

        // all q-values equal so the lowest index wins
        for (int i = 0; i < int'(wsn_pkg::MAX_NEIGHBORS); i++) begin
            write_word(wsn_pkg::QVALUE_BASE + wsn_pkg::addr_t'(i), 16'h1234);
        end
        run_scan(wsn_pkg::MAX_NEIGHBORS, wsn_pkg::nbr_idx_t'(rand_bits(6)));
        // 2-bit values repeat the max many times
        load_qvalues(2);
        run_scan(7'd40, wsn_pkg::nbr_idx_t'(rand_bits(6)));
        // two planted maxima at 5 and 40
        load_qvalues(8);
        write_word(wsn_pkg::QVALUE_BASE + 10'd5, 16'hFFFF);
        write_word(wsn_pkg::QVALUE_BASE + 10'd40, 16'hFFFF);
        run_scan(7'd48, wsn_pkg::nbr_idx_t'(rand_bits(6)));

        // stray starts during the scan and during the build
        load_qvalues(16);
        issue_scan(wsn_pkg::MAX_NEIGHBORS, wsn_pkg::nbr_idx_t'(rand_bits(6)));
        repeat (3) begin
            @(posedge done_prev);
            #1;
        end
        check_flag("busy", busy, 1'b1);
        pulse_start(7'd3, wsn_pkg::nbr_idx_t'(rand_bits(6)));
        repeat (int'(wsn_pkg::MAX_NEIGHBORS)) begin
            @(posedge done_prev);
            #1;
        end
        check_flag("busy", busy, 1'b1);
        pulse_start(7'd9, wsn_pkg::nbr_idx_t'(rand_bits(6)));
        wait_idle();
        repeat (RUN_CYCLES) @(posedge done_prev);
        #1;

        // zero count must leave no trace
        hop_mark = hop_cnt;
        done_mark = done_cnt;
        pulse_start(7'd0, wsn_pkg::nbr_idx_t'(rand_bits(6)));
        check_flag("busy", busy, 1'b0);
        repeat (RUN_CYCLES) @(posedge done_prev);
        #1;
        if ((hop_cnt != hop_mark) || (done_cnt != done_mark)) begin
            $display("start with zero neighbor count produced a hop_valid or done pulse");
            err_seq++;
        end

        // rewrite battery and destination words between runs
        act = wsn_pkg::nbr_idx_t'(rand_bits(6));
        write_word(wsn_pkg::BATTERY_BASE + wsn_pkg::addr_t'(node_id),
                   wsn_pkg::word_t'(rand_bits(16)));
        write_word(wsn_pkg::DEST_BASE + wsn_pkg::addr_t'(act), wsn_pkg::word_t'(rand_bits(7)));
        run_scan(7'd20, act);
        // new node id picks another battery word
        node_id = wsn_pkg::word_t'(rand_bits(7));
        write_word(wsn_pkg::BATTERY_BASE + wsn_pkg::addr_t'(node_id),
                   wsn_pkg::word_t'(rand_bits(16)));
        write_word(wsn_pkg::DEST_BASE + wsn_pkg::addr_t'(act), wsn_pkg::word_t'(rand_bits(7)));
        run_scan(7'd20, act);

        // late or extra pulses
        repeat (RUN_CYCLES) @(posedge done_prev);
        #1;
        if ((done_cnt != accepted_cnt) || (hop_cnt != accepted_cnt)) begin
            $display("saw %0d hop_valid and %0d done pulses for %0d accepted starts",
                     hop_cnt, done_cnt, accepted_cnt);
            err_seq++;
        end

        print_summary();
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== testbench/cluster_node_checker.sv ====
`timescale 1ns/100ps

module cluster_node_checker (
    input logic done_prev,
    input logic rst_n,
    input logic done,
    input logic hop_valid,
    input logic busy,
    input logic build_busy
);

    // failed assertions so far
    int fail_cnt = 0;

    // done is a single-cycle strobe
    done_single: assert property (
        @(posedge done_prev) disable iff (!rst_n)
        done |=> !done
    ) else begin
        fail_cnt++;
        $error("done stayed high for more than one cycle");
    end

    // fixed builder latency from hop_valid to done
    done_after_hop: assert property (
        @(posedge done_prev) disable iff (!rst_n)
        hop_valid |-> ##(wsn_pkg::BUILD_CYCLES) done
    ) else begin
        fail_cnt++;
        $error("done did not follow hop_valid after the build latency");
    end

    // no done without a matching hop_valid
    hop_before_done: assert property (
        @(posedge done_prev) disable iff (!rst_n)
        done |-> $past(hop_valid, wsn_pkg::BUILD_CYCLES)
    ) else begin
        fail_cnt++;
        $error("done rose without a hop_valid one build latency earlier");
    end

    // selector must hold off while a packet is being built
    no_hop_while_building: assert property (
        @(posedge done_prev) disable iff (!rst_n)
        !(hop_valid && build_busy)
    ) else begin
        fail_cnt++;
        $error("hop_valid raised while the builder was busy");
    end

    // everything quiet on the first edge out of reset
    quiet_after_reset: assert property (
        @(posedge done_prev)
        $rose(rst_n) |-> (!busy && !done && !hop_valid)
    ) else begin
        fail_cnt++;
        $error("busy, done or hop_valid high right after reset");
    end

endmodule

bind cluster_node cluster_node_checker chk_i (
    .done_prev  (done_prev),
    .rst_n      (rst_n),
    .done       (done),
    .hop_valid  (hop_valid),
    .busy       (busy),
    .build_busy (build_busy)
);

// ==== logic/cluster_node.sv ====
`timescale 1ns/100ps

module cluster_node (
    input  logic               done_prev,
    input  logic               rst_n,
    // static configuration
    input  wsn_pkg::word_t     node_id,
    input  wsn_pkg::word_t     cluster_id,
    // run request, action and count sampled with start
    input  logic               start,
    input  wsn_pkg::nbr_idx_t  action,
    input  wsn_pkg::nbr_cnt_t  neighbor_count,
    // memory load
    input  logic               wr_en,
    input  wsn_pkg::addr_t     wr_addr,
    input  wsn_pkg::word_t     wr_data,
    // results
    output wsn_pkg::feedback_t feedback,
    output logic               done,
    output wsn_pkg::nbr_idx_t  best_hop,
    output logic               hop_valid,
    output logic               busy
);

    // port a, selector side
    wsn_pkg::addr_t rd_a_addr;
    wsn_pkg::word_t rd_a_data;

    // port b, builder side
    wsn_pkg::addr_t rd_b_addr;
    wsn_pkg::word_t rd_b_data;

    // selector to builder hand-off
    wsn_pkg::word_t    best_q;
    wsn_pkg::nbr_idx_t action_q;
    logic              build_busy;

    node_memory mem_i (
        .done_prev (done_prev),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_a_addr (rd_a_addr),
        .rd_a_data (rd_a_data),
        .rd_b_addr (rd_b_addr),
        .rd_b_data (rd_b_data)
    );

    hop_selector sel_i (
        .done_prev      (done_prev),
        .rst_n          (rst_n),
        .start          (start),
        .action         (action),
        .neighbor_count (neighbor_count),
        .build_busy     (build_busy),
        .rd_a_addr      (rd_a_addr),
        .rd_a_data      (rd_a_data),
        .hop_valid      (hop_valid),
        .best_hop       (best_hop),
        .best_q         (best_q),
        .action_q       (action_q),
        .busy           (busy)
    );

    feedback_builder fb_i (
        .done_prev  (done_prev),
        .rst_n      (rst_n),
        .node_id    (node_id),
        .cluster_id (cluster_id),
        .hop_valid  (hop_valid),
        .best_q     (best_q),
        .action     (action_q),
        .rd_b_addr  (rd_b_addr),
        .rd_b_data  (rd_b_data),
        .feedback   (feedback),
        .done       (done),
        .build_busy (build_busy)
    );

endmodule

// ==== logic/feedback_builder.sv ====
`timescale 1ns/100ps

module feedback_builder (
    input  logic               done_prev,
    input  logic               rst_n,
    input  wsn_pkg::word_t     node_id,
    input  wsn_pkg::word_t     cluster_id,
    input  logic               hop_valid,
    input  wsn_pkg::word_t     best_q,
    input  wsn_pkg::nbr_idx_t  action,
    output wsn_pkg::addr_t     rd_b_addr,
    input  wsn_pkg::word_t     rd_b_data,
    output wsn_pkg::feedback_t feedback,
    output logic               done,
    output logic               build_busy
);

    wsn_pkg::fb_state_t state;

    // fields captured along the way
    wsn_pkg::word_t battery_q;
    wsn_pkg::word_t value_q;
    wsn_pkg::word_t dest_q;

    wsn_pkg::addr_t batt_addr;
    wsn_pkg::addr_t dest_addr;

    // node ids stay below 128, so the cast keeps the whole id
    assign batt_addr = wsn_pkg::BATTERY_BASE + wsn_pkg::addr_t'(node_id);

    // destination comes from the neighbor id the action selects
    assign dest_addr = wsn_pkg::DEST_BASE + wsn_pkg::addr_t'(action);

    // high from the first read until the packet is out
    assign build_busy = (state != wsn_pkg::FB_IDLE);

    // sequence per packet
    //   idle: battery address out
    //   batt: destination address out, battery read in flight
    //   qval: battery word lands, value taken from the selector
    //   dest: destination word lands
    //   pack: packet register and done
    always_ff @(posedge done_prev or negedge rst_n) begin
        if (!rst_n) begin
            state     <= wsn_pkg::FB_IDLE;
            rd_b_addr <= '0;
            feedback  <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;

            case (state)
                wsn_pkg::FB_IDLE: begin
                    if (hop_valid) begin
                        rd_b_addr <= batt_addr;
                        state     <= wsn_pkg::FB_BATT;
                    end
                end
                wsn_pkg::FB_BATT: begin
                    rd_b_addr <= dest_addr;
                    state     <= wsn_pkg::FB_QVAL;
                end
                wsn_pkg::FB_QVAL: begin
                    // no port b read for the value
                    // the selector already holds the best q-value
                    state <= wsn_pkg::FB_DEST;
                end
                wsn_pkg::FB_DEST: begin
                    state <= wsn_pkg::FB_PACK;
                end
                wsn_pkg::FB_PACK: begin
                    // most significant field first
                    feedback <= {node_id, battery_q, value_q, cluster_id, dest_q};
                    done     <= 1'b1;
                    state    <= wsn_pkg::FB_IDLE;
                end
                default: begin
                    state <= wsn_pkg::FB_IDLE;
                end
            endcase
        end
    end

    // field capture, payload only
    always_ff @(posedge done_prev) begin
        if (state == wsn_pkg::FB_QVAL) begin
            battery_q <= rd_b_data;
            value_q   <= best_q;
        end
        if (state == wsn_pkg::FB_DEST) begin
            dest_q <= rd_b_data;
        end
    end

endmodule

// ==== logic/hop_selector.sv ====
`timescale 1ns/100ps

module hop_selector (
    input  logic              done_prev,
    input  logic              rst_n,
    input  logic              start,
    input  wsn_pkg::nbr_idx_t action,
    input  wsn_pkg::nbr_cnt_t neighbor_count,
    input  logic              build_busy,
    output wsn_pkg::addr_t    rd_a_addr,
    input  wsn_pkg::word_t    rd_a_data,
    output logic              hop_valid,
    output wsn_pkg::nbr_idx_t best_hop,
    output wsn_pkg::word_t    best_q,
    output wsn_pkg::nbr_idx_t action_q,
    output logic              busy
);

    wsn_pkg::sel_state_t state;

    // latched neighbor count for this scan
    wsn_pkg::nbr_cnt_t cnt_q;
    wsn_pkg::nbr_cnt_t last_idx;
    wsn_pkg::nbr_cnt_t cnt_clamped;

    // next index to put on port a
    wsn_pkg::nbr_cnt_t issue_idx;
    // index of the q-value now on rd_a_data
    wsn_pkg::nbr_cnt_t cmp_idx;

    // two-stage valid, follows the memory read latency
    logic issue_vld;
    logic data_vld;

    logic accept;
    logic take;

    // only start in idle, with builder free and a real count
    assign accept = start && (state == wsn_pkg::SEL_IDLE) && !hop_valid &&
                    !build_busy && (neighbor_count != '0);

    // counts above the table size are cut to MAX_NEIGHBORS
    assign cnt_clamped = (neighbor_count > wsn_pkg::MAX_NEIGHBORS) ?
                         wsn_pkg::MAX_NEIGHBORS : neighbor_count;

    assign last_idx = cnt_q - 7'd1;

    // first value seeds the max, later ones must be strictly larger
    // so ties stay on the lowest index
    assign take = data_vld && ((cmp_idx == '0) || (rd_a_data > best_q));

    // busy covers the hand-off cycle and the whole build
    assign busy = (state != wsn_pkg::SEL_IDLE) || hop_valid || build_busy;

    always_ff @(posedge done_prev or negedge rst_n) begin
        if (!rst_n) begin
            state     <= wsn_pkg::SEL_IDLE;
            cnt_q     <= '0;
            issue_idx <= '0;
            cmp_idx   <= '0;
            issue_vld <= 1'b0;
            data_vld  <= 1'b0;
            hop_valid <= 1'b0;
            best_hop  <= '0;
            rd_a_addr <= '0;
        end else begin
            hop_valid <= 1'b0;
            issue_vld <= 1'b0;
            data_vld  <= issue_vld;

            case (state)
                wsn_pkg::SEL_IDLE: begin
                    if (accept) begin
                        cnt_q     <= cnt_clamped;
                        issue_idx <= '0;
                        cmp_idx   <= '0;
                        state     <= wsn_pkg::SEL_SCAN;
                    end
                end
                wsn_pkg::SEL_SCAN: begin
                    // one q-value address per cycle
                    rd_a_addr <= wsn_pkg::QVALUE_BASE + wsn_pkg::addr_t'(issue_idx);
                    issue_vld <= 1'b1;
                    issue_idx <= issue_idx + 7'd1;
                    if (issue_idx == last_idx) begin
                        state <= wsn_pkg::SEL_LAST;
                    end
                end
                wsn_pkg::SEL_LAST: begin
                    // wait for the tail of the read pipeline
                end
                default: begin
                    state <= wsn_pkg::SEL_IDLE;
                end
            endcase

            // compare stage, two cycles behind the address
            if (data_vld) begin
                cmp_idx <= cmp_idx + 7'd1;
                if (take) begin
                    best_hop <= cmp_idx[wsn_pkg::NBR_IDX_WIDTH-1:0];
                end
                if (cmp_idx == last_idx) begin
                    hop_valid <= 1'b1;
                    state     <= wsn_pkg::SEL_IDLE;
                end
            end
        end
    end

    // payload, held until the next accepted start
    always_ff @(posedge done_prev) begin
        if (accept) begin
            action_q <= action;
        end
        if (take) begin
            best_q <= rd_a_data;
        end
    end

endmodule

// ==== logic/node_memory.sv ====
`timescale 1ns/100ps

module node_memory (
    input  logic           done_prev,
    input  logic           rst_n,
    // load port
    input  logic           wr_en,
    input  wsn_pkg::addr_t wr_addr,
    input  wsn_pkg::word_t wr_data,
    // port a, hop selector
    input  wsn_pkg::addr_t rd_a_addr,
    output wsn_pkg::word_t rd_a_data,
    // port b, feedback builder
    input  wsn_pkg::addr_t rd_b_addr,
    output wsn_pkg::word_t rd_b_data
);

    // word-addressed storage, no reset on contents
    wsn_pkg::word_t mem [wsn_pkg::MEM_DEPTH];

    // single synchronous write port
    always_ff @(posedge done_prev) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered reads
    // data shows up one edge after the address is sampled
    // a same-address write returns the old word
    always_ff @(posedge done_prev or negedge rst_n) begin
        if (!rst_n) begin
            rd_a_data <= '0;
        end else begin
            rd_a_data <= mem[rd_a_addr];
        end
    end

    // port b has its own output register
    always_ff @(posedge done_prev or negedge rst_n) begin
        if (!rst_n) begin
            rd_b_data <= '0;
        end else begin
            rd_b_data <= mem[rd_b_addr];
        end
    end

endmodule

// ==== logic/wsn_pkg.sv ====
package wsn_pkg;

    // basic field widths
    localparam int WORD_WIDTH = 16;
    localparam int ADDR_WIDTH = 10;
    localparam int NBR_IDX_WIDTH = 6;
    localparam int NBR_CNT_WIDTH = 7;

    // five 16-bit fields per feedback packet
    localparam int FEEDBACK_FIELDS = 5;
    localparam int FEEDBACK_WIDTH = FEEDBACK_FIELDS * WORD_WIDTH;

    // data word: ids, battery level, q-values
    typedef logic [WORD_WIDTH-1:0] word_t;

    // word address into node memory
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // neighbor index, 0..63
    typedef logic [NBR_IDX_WIDTH-1:0] nbr_idx_t;

    // neighbor count, 0..64
    typedef logic [NBR_CNT_WIDTH-1:0] nbr_cnt_t;

    // {source id, battery, value, cluster id, destination id}
    typedef logic [FEEDBACK_WIDTH-1:0] feedback_t;

    // node memory size in words
    localparam int MEM_DEPTH = 1 << ADDR_WIDTH;

    // memory map, word addresses
    // neighbor id table, indexed by action
    localparam addr_t DEST_BASE = 10'h048;
    // battery table, indexed by node id
    localparam addr_t BATTERY_BASE = 10'h148;
    // q-value table, indexed by neighbor index
    localparam addr_t QVALUE_BASE = 10'h1C8;

    // upper bound on neighbors per scan
    localparam nbr_cnt_t MAX_NEIGHBORS = 7'd64;

    // hop_valid to done, in cycles
    localparam int BUILD_CYCLES = 5;

    // hop selector states
    typedef enum logic [1:0] {
        SEL_IDLE,
        SEL_SCAN,
        SEL_LAST
    } sel_state_t;

    // feedback builder states
    typedef enum logic [2:0] {
        FB_IDLE,
        FB_BATT,
        FB_QVAL,
        FB_DEST,
        FB_PACK
    } fb_state_t;

endpackage
